/* hdl/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] word_t;      // Data word, pc, vectors
    typedef logic [11:0] csr_addr_t;  // CSR address field

    // Privilege levels, no hypervisor
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,  // csrrw
        CMD_S     = 3'd2,  // csrrs
        CMD_C     = 3'd3,  // csrrc
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5,
        CMD_SRET  = 3'd6
    } csr_cmd_e;

    // Supervisor trap setup and handling
    localparam csr_addr_t ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t ADDR_SIE      = 12'h104;
    localparam csr_addr_t ADDR_STVEC    = 12'h105;
    localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
    localparam csr_addr_t ADDR_SEPC     = 12'h141;
    localparam csr_addr_t ADDR_SCAUSE   = 12'h142;
    localparam csr_addr_t ADDR_SIP      = 12'h144;
    // Machine trap setup and handling
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIDELEG  = 12'h303;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MIP      = 12'h344;

    localparam word_t CAUSE_ECALL_U = 32'd8;  // Plus current mode
    localparam word_t CAUSE_SSI     = 32'h8000_0001;
    localparam word_t CAUSE_MSI     = 32'h8000_0003;
    localparam word_t CAUSE_STI     = 32'h8000_0005;
    localparam word_t CAUSE_MTI     = 32'h8000_0007;
    localparam word_t CAUSE_SEI     = 32'h8000_0009;
    localparam word_t CAUSE_MEI     = 32'h8000_000b;

    // mstatus field positions
    localparam int STS_SIE    = 1;
    localparam int STS_MIE    = 3;
    localparam int STS_SPIE   = 5;
    localparam int STS_MPIE   = 7;
    localparam int STS_SPP    = 8;
    localparam int STS_MPP_LO = 11;
    localparam int STS_MPP_HI = 12;

    // Interrupt bit positions in mip, mie, mideleg
    localparam int IRQ_SSI = 1;
    localparam int IRQ_MSI = 3;
    localparam int IRQ_STI = 5;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_SEI = 9;
    localparam int IRQ_MEI = 11;

    localparam word_t IRQ_MASK     = 32'h0000_0aaa;
    localparam word_t S_IRQ_MASK   = 32'h0000_0222;
    localparam word_t SSTATUS_MASK = 32'h0000_0122;
    localparam word_t MSTATUS_MASK = 32'h0000_19aa;
    localparam word_t MIP_SW_MASK  = 32'h0000_0222;  // SSIP, STIP, SEIP

    // MXL=1, extensions I M S U
    localparam word_t MISA_VALUE = 32'h4014_1100;

endpackage

/* hdl/csr_bus_if.sv */
`timescale 1ns/10ps

interface csr_bus_if
    import csr_pkg::*;
();

    csr_addr_t addr;   // Address of current access
    logic      rd_en;  // Read permitted this cycle
    logic      wr_en;  // Write at next edge
    word_t     wdata;  // Read-modify-write result
    word_t     rdata;  // Old CSR value, zero when rd_en low

    modport access (
        output addr, rd_en, wr_en, wdata,
        input  rdata
    );

    modport regs (
        input  addr, rd_en, wr_en, wdata,
        output rdata
    );

    // Status holder only snoops writes
    modport status (
        input addr, wr_en, wdata
    );

endinterface

/* hdl/trap_if.sv */
`timescale 1ns/10ps

interface trap_if
    import csr_pkg::*;
();

    logic  take;   // Trap taken this cycle
    logic  to_m;   // Target M, else S
    word_t cause;  // Value for xcause
    word_t epc;    // Value for xepc
    logic  mret;
    logic  sret;

    modport ctrl (
        output take, to_m, cause, epc, mret, sret
    );

    modport state (
        input take, to_m, cause, epc, mret, sret
    );

endinterface

/* hdl/csr_access.sv */
`timescale 1ns/10ps

module csr_access
    import csr_pkg::*;
(
    input  logic      valid,
    input  csr_cmd_e  cmd,
    input  csr_addr_t csr_addr,
    input  word_t     op1,
    input  mode_e     mode,
    input  logic      trap_take,
    csr_bus_if.access bus
);

    logic is_rw;      // W, S or C command
    logic can_read;
    logic can_write;

    // Address bits 9:8 hold the lowest privilege allowed
    assign can_read  = csr_addr[9:8] <= mode;
    assign can_write = can_read && (csr_addr[11:10] != 2'b11);  // 11 means read-only

    always_comb begin
        case (cmd)
            CMD_W, CMD_S, CMD_C: is_rw = 1'b1;
            default:             is_rw = 1'b0;
        endcase
    end

    assign bus.addr  = csr_addr;
    assign bus.rd_en = valid && is_rw && can_read;
    // Trap in same cycle wins over the write
    assign bus.wr_en = valid && is_rw && can_write && !trap_take;

    // Read-modify-write on the old value
    always_comb begin
        case (cmd)
            CMD_W:   bus.wdata = op1;
            CMD_S:   bus.wdata = bus.rdata | op1;
            CMD_C:   bus.wdata = bus.rdata & ~op1;
            default: bus.wdata = '0;
        endcase
    end

endmodule

/* hdl/priv_state.sv */
`timescale 1ns/10ps

module priv_state
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    csr_bus_if.status bus,
    trap_if.state     trap,
    output mode_e     mode,
    output word_t     status
);

    // mstatus interrupt-enable and previous-mode stack
    logic       s_ie;
    logic       m_ie;
    logic       s_pie;
    logic       m_pie;
    logic       s_pp;
    logic [1:0] m_pp;

    logic  sts_wr;   // Write hits mstatus or sstatus
    word_t wr_mask;
    word_t wr_val;   // Merged new status word

    always_comb begin
        status                        = '0;
        status[STS_SIE]               = s_ie;
        status[STS_MIE]               = m_ie;
        status[STS_SPIE]              = s_pie;
        status[STS_MPIE]              = m_pie;
        status[STS_SPP]               = s_pp;
        status[STS_MPP_HI:STS_MPP_LO] = m_pp;
    end

    assign sts_wr  = bus.wr_en && (bus.addr == ADDR_MSTATUS || bus.addr == ADDR_SSTATUS);
    assign wr_mask = (bus.addr == ADDR_MSTATUS) ? MSTATUS_MASK : SSTATUS_MASK;  // sstatus view
    assign wr_val  = (status & ~wr_mask) | (bus.wdata & wr_mask);

    always_ff @(posedge clk) begin
        if (reset) begin
            mode  <= M_MODE;
            s_ie  <= 1'b0;
            m_ie  <= 1'b0;
            s_pie <= 1'b0;
            m_pie <= 1'b0;
            s_pp  <= 1'b0;
            m_pp  <= M_MODE;
        end else if (trap.take) begin
            if (trap.to_m) begin
                m_pie <= m_ie;
                m_ie  <= 1'b0;
                m_pp  <= mode;
                mode  <= M_MODE;
            end else begin
                s_pie <= s_ie;
                s_ie  <= 1'b0;
                s_pp  <= mode[0];   // Only U or S can trap to S
                mode  <= S_MODE;
            end
        end else if (trap.mret) begin
            m_ie  <= m_pie;
            mode  <= mode_e'(m_pp);
            m_pie <= 1'b1;
            m_pp  <= U_MODE;
        end else if (trap.sret) begin
            s_ie  <= s_pie;
            mode  <= mode_e'({1'b0, s_pp});
            s_pie <= 1'b1;
            s_pp  <= 1'b0;
        end else if (sts_wr) begin
            s_ie  <= wr_val[STS_SIE];
            m_ie  <= wr_val[STS_MIE];
            s_pie <= wr_val[STS_SPIE];
            m_pie <= wr_val[STS_MPIE];
            s_pp  <= wr_val[STS_SPP];
            // MPP=2 is not a mode here, keep old value
            if (wr_val[STS_MPP_HI:STS_MPP_LO] != 2'b10) begin
                m_pp <= wr_val[STS_MPP_HI:STS_MPP_LO];
            end
        end
    end

endmodule

/* hdl/csr_regs.sv */
`timescale 1ns/10ps

module csr_regs
    import csr_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    ext_irq,
    input  word_t   status,
    csr_bus_if.regs bus,
    trap_if.state   trap,
    output word_t   irq_pend,
    output word_t   irq_en,
    output word_t   irq_deleg,
    output word_t   mtvec,
    output word_t   stvec,
    output word_t   mepc,
    output word_t   sepc
);

    word_t ip_sw;     // Software pending bits
    logic  meip;      // External line, sampled
    word_t mscratch;
    word_t sscratch;
    word_t mcause;
    word_t scause;
    word_t rd_val;    // Mux output before gating

    // Hardware MEIP joins the software bits
    assign irq_pend = ip_sw | (word_t'(meip) << IRQ_MEI);

    always_ff @(posedge clk) begin
        if (reset) begin
            ip_sw     <= '0;
            meip      <= 1'b0;
            irq_en    <= '0;
            irq_deleg <= '0;
            mtvec     <= '0;
            stvec     <= '0;
            mscratch  <= '0;
            sscratch  <= '0;
            mepc      <= '0;
            sepc      <= '0;
            mcause    <= '0;
            scause    <= '0;
        end else begin
            meip <= ext_irq;
            if (trap.take) begin
                if (trap.to_m) begin
                    mcause <= trap.cause;
                    mepc   <= trap.epc;
                end else begin
                    scause <= trap.cause;
                    sepc   <= trap.epc;
                end
            end else if (bus.wr_en) begin
                case (bus.addr)
                    ADDR_MIDELEG:  irq_deleg <= bus.wdata & IRQ_MASK;
                    ADDR_MIE:      irq_en    <= bus.wdata & IRQ_MASK;
                    // sie reaches only the S bits of mie
                    ADDR_SIE:      irq_en    <= (irq_en & ~S_IRQ_MASK) | (bus.wdata & S_IRQ_MASK);
                    ADDR_MIP,
                    ADDR_SIP:      ip_sw     <= bus.wdata & MIP_SW_MASK;
                    ADDR_MTVEC:    mtvec     <= bus.wdata;
                    ADDR_STVEC:    stvec     <= bus.wdata;
                    ADDR_MSCRATCH: mscratch  <= bus.wdata;
                    ADDR_SSCRATCH: sscratch  <= bus.wdata;
                    ADDR_MEPC:     mepc      <= {bus.wdata[31:2], 2'b00};  // Word aligned
                    ADDR_SEPC:     sepc      <= {bus.wdata[31:2], 2'b00};
                    ADDR_MCAUSE:   mcause    <= bus.wdata;
                    ADDR_SCAUSE:   scause    <= bus.wdata;
                    default: ;     // Status owned by priv_state, misa fixed
                endcase
            end
        end
    end

    // Read mux, S views through masks
    always_comb begin
        case (bus.addr)
            ADDR_MSTATUS:  rd_val = status;
            ADDR_SSTATUS:  rd_val = status & SSTATUS_MASK;
            ADDR_MISA:     rd_val = MISA_VALUE;
            ADDR_MIDELEG:  rd_val = irq_deleg;
            ADDR_MIE:      rd_val = irq_en;
            ADDR_SIE:      rd_val = irq_en & S_IRQ_MASK;
            ADDR_MIP:      rd_val = irq_pend;
            ADDR_SIP:      rd_val = irq_pend & S_IRQ_MASK;
            ADDR_MTVEC:    rd_val = mtvec;
            ADDR_STVEC:    rd_val = stvec;
            ADDR_MSCRATCH: rd_val = mscratch;
            ADDR_SSCRATCH: rd_val = sscratch;
            ADDR_MEPC:     rd_val = mepc;
            ADDR_SEPC:     rd_val = sepc;
            ADDR_MCAUSE:   rd_val = mcause;
            ADDR_SCAUSE:   rd_val = scause;
            default:       rd_val = '0;
        endcase
    end

    assign bus.rdata = bus.rd_en ? rd_val : '0;  // No access reads zero

endmodule

/* hdl/trap_ctrl.sv */
`timescale 1ns/10ps

module trap_ctrl
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     valid,
    input  csr_cmd_e cmd,
    input  word_t    pc,
    input  mode_e    mode,
    input  word_t    status,
    input  word_t    irq_pend,
    input  word_t    irq_en,
    input  word_t    irq_deleg,
    input  word_t    mtvec,
    input  word_t    stvec,
    input  word_t    mepc,
    input  word_t    sepc,
    trap_if.ctrl     trap,
    output logic     trap_flg,
    output word_t    trap_vector
);

    logic  ecall;
    logic  m_ok;       // Global enable for M target
    logic  s_ok;       // Global enable for S target
    logic  irq_take;
    logic  to_s;       // Winning interrupt is delegated
    word_t elig;       // Pending, enabled and allowed
    word_t irq_cause;
    word_t base;       // Selected xtvec
    word_t vec;

    assign m_ok = (mode != M_MODE) || status[STS_MIE];
    assign s_ok = (mode == U_MODE) || (mode == S_MODE && status[STS_SIE]);  // Never in M
    assign elig = irq_pend & irq_en & ((~irq_deleg & {32{m_ok}}) | (irq_deleg & {32{s_ok}}));

    // Fixed priority MEI MSI MTI SEI SSI STI
    always_comb begin
        if (elig[IRQ_MEI])      irq_cause = CAUSE_MEI;
        else if (elig[IRQ_MSI]) irq_cause = CAUSE_MSI;
        else if (elig[IRQ_MTI]) irq_cause = CAUSE_MTI;
        else if (elig[IRQ_SEI]) irq_cause = CAUSE_SEI;
        else if (elig[IRQ_SSI]) irq_cause = CAUSE_SSI;
        else if (elig[IRQ_STI]) irq_cause = CAUSE_STI;
        else                    irq_cause = '0;
    end

    assign irq_take = irq_cause[31];
    assign to_s     = irq_deleg[irq_cause[4:0]];
    assign ecall    = valid && (cmd == CMD_ECALL);

    // ecall goes to M and wins over interrupts
    assign trap.take  = ecall || (valid && irq_take);
    assign trap.to_m  = ecall || !to_s;
    assign trap.cause = ecall ? CAUSE_ECALL_U + word_t'(mode) : irq_cause;
    assign trap.epc   = pc;
    assign trap.mret  = valid && (cmd == CMD_MRET) && !trap.take;
    assign trap.sret  = valid && (cmd == CMD_SRET) && !trap.take;

    assign trap_flg = trap.take || trap.mret || trap.sret;

    // Vectored mode adds 4 * code for interrupts only
    assign base = trap.to_m ? mtvec : stvec;
    assign vec  = {base[31:2], 2'b00} +
                  ((base[0] && !ecall) ? {irq_cause[29:0], 2'b00} : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            trap_vector <= '0;
        end else if (trap.take) begin
            trap_vector <= vec;
        end else if (trap.mret) begin
            trap_vector <= mepc;
        end else if (trap.sret) begin
            trap_vector <= sepc;
        end
    end

endmodule

/* hdl/csr_unit.sv */
`timescale 1ns/10ps

module csr_unit
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      valid,
    input  logic      ext_irq,     // Machine external interrupt line
    input  csr_cmd_e  cmd,
    input  csr_addr_t csr_addr,
    input  word_t     pc,
    input  word_t     op1,
    output word_t     rdata,
    output logic      trap_flg,
    output word_t     trap_vector  // One cycle after trap_flg
);

    csr_bus_if i_bus ();
    trap_if    i_trap_bus ();

    mode_e mode;
    word_t status;
    word_t irq_pend;
    word_t irq_en;
    word_t irq_deleg;
    word_t mtvec;
    word_t stvec;
    word_t mepc;
    word_t sepc;

    assign rdata = i_bus.rdata;

    csr_access i_access (
        .valid     (valid),
        .cmd       (cmd),
        .csr_addr  (csr_addr),
        .op1       (op1),
        .mode      (mode),
        .trap_take (i_trap_bus.take),   // Blocks the write on a trap
        .bus       (i_bus.access)
    );

    priv_state i_priv (
        .clk    (clk),
        .reset  (reset),
        .bus    (i_bus.status),
        .trap   (i_trap_bus.state),
        .mode   (mode),
        .status (status)
    );

    csr_regs i_regs (
        .clk       (clk),
        .reset     (reset),
        .ext_irq   (ext_irq),
        .status    (status),
        .bus       (i_bus.regs),
        .trap      (i_trap_bus.state),
        .irq_pend  (irq_pend),
        .irq_en    (irq_en),
        .irq_deleg (irq_deleg),
        .mtvec     (mtvec),
        .stvec     (stvec),
        .mepc      (mepc),
        .sepc      (sepc)
    );

    trap_ctrl i_trap (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .cmd         (cmd),
        .pc          (pc),
        .mode        (mode),
        .status      (status),
        .irq_pend    (irq_pend),
        .irq_en      (irq_en),
        .irq_deleg   (irq_deleg),
        .mtvec       (mtvec),
        .stvec       (stvec),
        .mepc        (mepc),
        .sepc        (sepc),
        .trap        (i_trap_bus.ctrl),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector)
    );

endmodule

/* dv/csr_unit_tb.sv */
`timescale 1ns/10ps

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int PRIV_ROUNDS = 24;
    localparam int IRQ_ROUNDS  = 40;
    // Upper bound of one-cycle commands per test
    localparam int RW_CMDS     = 205;
    localparam int PRIV_CMDS   = PRIV_ROUNDS * 25;
    localparam int IRQ_CMDS    = IRQ_ROUNDS * 18;
    localparam int WATCHDOG_NS = (5 + RW_CMDS + PRIV_CMDS + IRQ_CMDS + 50) * 40;

    logic      clk;
    logic      reset;
    logic      valid;
    logic      ext_irq;
    csr_cmd_e  cmd;
    csr_addr_t csr_addr;
    word_t     pc;
    word_t     op1;
    word_t     rdata;
    logic      trap_flg;
    word_t     trap_vector;

    logic [15:0] lfsr;
    string       test_name;
    logic        irq_noise;  // Random ext_irq per command
    int          n_irq;      // Interrupt traps seen by the model

    // Reference model state
    mode_e mdl_mode;
    word_t mdl_status;   // Only the mstatus fields that exist
    word_t mdl_deleg;
    word_t mdl_ie;
    word_t mdl_ipsw;     // Software pending bits
    logic  mdl_meip;     // ext_irq seen at the last edge
    word_t mdl_mtvec;
    word_t mdl_stvec;
    word_t mdl_mscratch;
    word_t mdl_sscratch;
    word_t mdl_mepc;
    word_t mdl_sepc;
    word_t mdl_mcause;
    word_t mdl_scause;
    word_t mdl_vec;      // Expected trap_vector register
    word_t exp_rdata;
    logic  exp_flg;

    csr_unit i_dut (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .ext_irq     (ext_irq),
        .cmd         (cmd),
        .csr_addr    (csr_addr),
        .pc          (pc),
        .op1         (op1),
        .rdata       (rdata),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 16'hb400;
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic csr_addr_t kept_addr(input word_t idx);
        case (idx)
            0:       return ADDR_SSTATUS;
            1:       return ADDR_SIE;
            2:       return ADDR_STVEC;
            3:       return ADDR_SSCRATCH;
            4:       return ADDR_SEPC;
            5:       return ADDR_SCAUSE;
            6:       return ADDR_SIP;
            7:       return ADDR_MSTATUS;
            8:       return ADDR_MISA;
            9:       return ADDR_MIDELEG;
            10:      return ADDR_MIE;
            11:      return ADDR_MTVEC;
            12:      return ADDR_MSCRATCH;
            13:      return ADDR_MEPC;
            14:      return ADDR_MCAUSE;
            default: return ADDR_MIP;
        endcase
    endfunction

    function automatic mode_e pick_mode();
        case (rand_bits(2))
            0:       return U_MODE;
            1:       return S_MODE;
            default: return M_MODE;
        endcase
    endfunction

    function automatic word_t status_word(input mode_e mpp, input logic mpie, input logic sie);
        word_t w;
        w = '0;
        w[STS_MPP_HI:STS_MPP_LO] = mpp;
        w[STS_MPIE]              = mpie;
        w[STS_SIE]               = sie;
        return w;
    endfunction

    // Interrupt bit by priority rank with MEI highest
    function automatic int prio_bit(input int rank);
        case (rank)
            0:       return IRQ_MEI;
            1:       return IRQ_MSI;
            2:       return IRQ_MTI;
            3:       return IRQ_SEI;
            4:       return IRQ_SSI;
            default: return IRQ_STI;
        endcase
    endfunction

    function automatic void reset_model();
        mdl_mode     = M_MODE;
        mdl_status   = '0;
        mdl_status[STS_MPP_HI:STS_MPP_LO] = M_MODE;
        mdl_deleg    = '0;
        mdl_ie       = '0;
        mdl_ipsw     = '0;
        mdl_meip     = 1'b0;
        mdl_mtvec    = '0;
        mdl_stvec    = '0;
        mdl_mscratch = '0;
        mdl_sscratch = '0;
        mdl_mepc     = '0;
        mdl_sepc     = '0;
        mdl_mcause   = '0;
        mdl_scause   = '0;
        mdl_vec      = '0;
    endfunction

    function automatic word_t pending();
        return mdl_ipsw | (word_t'(mdl_meip) << IRQ_MEI);
    endfunction

    function automatic word_t csr_value(input csr_addr_t a);
        case (a)
            ADDR_MSTATUS:  return mdl_status;
            ADDR_SSTATUS:  return mdl_status & SSTATUS_MASK;  // S view
            ADDR_MISA:     return MISA_VALUE;
            ADDR_MIDELEG:  return mdl_deleg;
            ADDR_MIE:      return mdl_ie;
            ADDR_SIE:      return mdl_ie & S_IRQ_MASK;
            ADDR_MIP:      return pending();
            ADDR_SIP:      return pending() & S_IRQ_MASK;
            ADDR_MTVEC:    return mdl_mtvec;
            ADDR_STVEC:    return mdl_stvec;
            ADDR_MSCRATCH: return mdl_mscratch;
            ADDR_SSCRATCH: return mdl_sscratch;
            ADDR_MEPC:     return mdl_mepc;
            ADDR_SEPC:     return mdl_sepc;
            ADDR_MCAUSE:   return mdl_mcause;
            ADDR_SCAUSE:   return mdl_scause;
            default:       return '0;
        endcase
    endfunction

    function automatic void write_csr(input csr_addr_t a, input word_t nv);
        logic [1:0] mpp_old;
        mpp_old = mdl_status[STS_MPP_HI:STS_MPP_LO];
        case (a)
            ADDR_MSTATUS: begin
                mdl_status = (mdl_status & ~MSTATUS_MASK) | (nv & MSTATUS_MASK);
                if (nv[STS_MPP_HI:STS_MPP_LO] == 2'b10) begin
                    mdl_status[STS_MPP_HI:STS_MPP_LO] = mpp_old;  // Reserved MPP keeps old value
                end
            end
            ADDR_SSTATUS:  mdl_status   = (mdl_status & ~SSTATUS_MASK) | (nv & SSTATUS_MASK);
            ADDR_MIDELEG:  mdl_deleg    = nv & IRQ_MASK;
            ADDR_MIE:      mdl_ie       = nv & IRQ_MASK;
            ADDR_SIE:      mdl_ie       = (mdl_ie & ~S_IRQ_MASK) | (nv & S_IRQ_MASK);
            ADDR_MIP,
            ADDR_SIP:      mdl_ipsw     = nv & MIP_SW_MASK;
            ADDR_MTVEC:    mdl_mtvec    = nv;
            ADDR_STVEC:    mdl_stvec    = nv;
            ADDR_MSCRATCH: mdl_mscratch = nv;
            ADDR_SSCRATCH: mdl_sscratch = nv;
            ADDR_MEPC:     mdl_mepc     = nv & ~32'h3;
            ADDR_SEPC:     mdl_sepc     = nv & ~32'h3;
            ADDR_MCAUSE:   mdl_mcause   = nv;
            ADDR_SCAUSE:   mdl_scause   = nv;
            default: ;  // misa is fixed
        endcase
    endfunction

    // Expected rdata and trap_flg of this cycle, then the state after the edge
    function automatic void predict_cycle(input logic v, input csr_cmd_e c,
                                          input csr_addr_t a, input word_t op,
                                          input word_t pc_in, input logic ext);
        logic  rw;
        logic  rd_ok;
        logic  ecall;
        logic  irq;
        logic  deleg;
        logic  dg;
        logic  allowed;
        logic  to_m;
        logic  take;
        logic  mret;
        logic  sret;
        int    code;
        word_t old;
        word_t nv;
        word_t act;
        word_t cause;
        word_t base;
        word_t vec;
        rw    = v && (c == CMD_W || c == CMD_S || c == CMD_C);
        rd_ok = int'(a[9:8]) <= int'(mdl_mode);  // Lowest level in bits 9:8
        old   = (rw && rd_ok) ? csr_value(a) : '0;
        act   = pending() & mdl_ie;
        irq   = 1'b0;
        deleg = 1'b0;
        code  = 0;
        for (int i = 0; i < 6; i++) begin
            if (!irq && act[prio_bit(i)]) begin
                dg = mdl_deleg[prio_bit(i)];
                if (dg) allowed = mdl_mode == U_MODE || (mdl_mode == S_MODE && mdl_status[STS_SIE]);
                else    allowed = mdl_mode != M_MODE || mdl_status[STS_MIE];
                if (allowed) begin
                    irq   = 1'b1;
                    deleg = dg;
                    code  = prio_bit(i);
                end
            end
        end
        ecall = v && c == CMD_ECALL;
        take  = ecall || (v && irq);
        to_m  = ecall || !deleg;  // ecall always to M
        cause = ecall ? CAUSE_ECALL_U + word_t'(mdl_mode) : (32'h8000_0000 | word_t'(code));
        base  = to_m ? mdl_mtvec : mdl_stvec;
        vec   = base & ~32'h3;
        if (!ecall && base[0]) vec = vec + word_t'(4 * code);  // Vectored
        mret  = v && c == CMD_MRET && !take;
        sret  = v && c == CMD_SRET && !take;
        nv    = (c == CMD_W) ? op : (c == CMD_S) ? (old | op) : (old & ~op);
        exp_rdata = old;
        exp_flg   = take || mret || sret;
        mdl_meip  = ext;
        if (take) begin
            if (!ecall) n_irq++;
            mdl_vec = vec;
            if (to_m) begin
                mdl_mcause            = cause;
                mdl_mepc              = pc_in;
                mdl_status[STS_MPIE]  = mdl_status[STS_MIE];
                mdl_status[STS_MIE]   = 1'b0;
                mdl_status[STS_MPP_HI:STS_MPP_LO] = mdl_mode;
                mdl_mode              = M_MODE;
            end else begin
                mdl_scause            = cause;
                mdl_sepc              = pc_in;
                mdl_status[STS_SPIE]  = mdl_status[STS_SIE];
                mdl_status[STS_SIE]   = 1'b0;
                mdl_status[STS_SPP]   = (mdl_mode == S_MODE);
                mdl_mode              = S_MODE;
            end
        end else if (mret) begin
            mdl_vec              = mdl_mepc;
            mdl_status[STS_MIE]  = mdl_status[STS_MPIE];
            mdl_mode             = mode_e'(mdl_status[STS_MPP_HI:STS_MPP_LO]);
            mdl_status[STS_MPIE] = 1'b1;
            mdl_status[STS_MPP_HI:STS_MPP_LO] = U_MODE;
        end else if (sret) begin
            mdl_vec              = mdl_sepc;
            mdl_status[STS_SIE]  = mdl_status[STS_SPIE];
            mdl_mode             = mdl_status[STS_SPP] ? S_MODE : U_MODE;
            mdl_status[STS_SPIE] = 1'b1;
            mdl_status[STS_SPP]  = 1'b0;
        end else if (rw && rd_ok && a[11:10] != 2'b11) begin
            write_csr(a, nv);  // Trap in same cycle drops it
        end
    endfunction

    task automatic check(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Value check failed");
        end
    endtask

    // Compare at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            check({test_name, " trap_vector"}, mdl_vec, trap_vector);
            predict_cycle(valid, cmd, csr_addr, op1, pc, ext_irq);
            check({test_name, " rdata"}, exp_rdata, rdata);
            check({test_name, " trap_flg"}, {31'b0, exp_flg}, {31'b0, trap_flg});
        end
    end

    task automatic drive(input logic v, input csr_cmd_e c, input csr_addr_t a, input word_t op);
        word_t pc_r;
        logic  ext;
        pc_r = rand_bits(32);
        ext  = 1'b0;
        if (irq_noise) ext = lfsr_bit();
        @(posedge clk);
        valid    <= v;
        cmd      <= c;
        csr_addr <= a;
        op1      <= op;
        pc       <= pc_r;
        ext_irq  <= ext;
    endtask

    task automatic random_access();
        csr_cmd_e c;
        case (rand_bits(2))
            1:       c = CMD_S;
            2:       c = CMD_C;
            default: c = CMD_W;
        endcase
        drive(1'b1, c, kept_addr(rand_bits(4)), rand_bits(32));
    endtask

    task automatic read_csr(input csr_addr_t a);
        drive(1'b1, CMD_S, a, '0);  // Set with zero only reads
    endtask

    // Back to M with interrupts off and nothing enabled
    task automatic settle_in_m();
        drive(1'b1, CMD_ECALL, ADDR_MSTATUS, '0);
        drive(1'b1, CMD_W, ADDR_MIE, '0);
        drive(1'b1, CMD_W, ADDR_MIP, '0);
        drive(1'b1, CMD_W, ADDR_MIDELEG, '0);
        drive(1'b1, CMD_W, ADDR_MSTATUS, '0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    initial begin
        mode_e tgt;
        lfsr      = 16'd5416;
        reset     = 1'b1;
        valid     = 1'b0;
        ext_irq   = 1'b0;
        cmd       = CMD_NONE;
        csr_addr  = '0;
        pc        = '0;
        op1       = '0;
        irq_noise = 1'b0;
        n_irq     = 0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_name = "m_mode_rw";
        settle_in_m();
        repeat (200) random_access();

        // MRET down, access rights, SRET, ecall back up
        test_name = "priv_levels";
        for (int r = 0; r < PRIV_ROUNDS; r++) begin
            settle_in_m();
            tgt = lfsr_bit() ? S_MODE : U_MODE;
            drive(1'b1, CMD_W, ADDR_MTVEC, rand_bits(32));
            drive(1'b1, CMD_W, ADDR_MEPC, rand_bits(32));
            drive(1'b1, CMD_W, ADDR_MSTATUS, status_word(tgt, lfsr_bit(), 1'b0));
            drive(1'b1, CMD_MRET, ADDR_MSTATUS, '0);
            repeat (6) random_access();
            if (tgt == S_MODE) begin
                drive(1'b1, CMD_W, ADDR_SEPC, rand_bits(32));
                drive(1'b1, CMD_W, ADDR_SSTATUS, rand_bits(32));  // Random SPP and SPIE
                drive(1'b1, CMD_SRET, ADDR_SSTATUS, '0);
                repeat (3) random_access();
            end
            drive(1'b1, CMD_ECALL, ADDR_MSTATUS, '0);
            read_csr(ADDR_MCAUSE);
            read_csr(ADDR_MEPC);
            read_csr(ADDR_MSTATUS);
        end

        test_name = "interrupts";
        irq_noise = 1'b1;
        for (int r = 0; r < IRQ_ROUNDS; r++) begin
            settle_in_m();
            drive(1'b1, CMD_W, ADDR_MTVEC, rand_bits(32));
            drive(1'b1, CMD_W, ADDR_STVEC, rand_bits(32));
            drive(1'b1, CMD_W, ADDR_MIDELEG, rand_bits(32));
            drive(1'b1, CMD_W, ADDR_MIE, rand_bits(32));
            drive(1'b1, CMD_W, ADDR_MIP, rand_bits(32));
            drive(1'b1, CMD_W, ADDR_MSTATUS, status_word(pick_mode(), lfsr_bit(), lfsr_bit()));
            drive(1'b1, CMD_MRET, ADDR_MSTATUS, '0);
            repeat (4) drive(1'b1, CMD_NONE, ADDR_MSTATUS, '0);  // Room to take one
            read_csr(ADDR_MCAUSE);
            read_csr(ADDR_SCAUSE);
        end
        irq_noise = 1'b0;

        repeat (2) drive(1'b0, CMD_NONE, '0, '0);
        @(negedge clk);
        #1;
        if (n_irq > 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("The stimulus never took an interrupt");
            $display("Simulation failed");
            $fatal(1, "Weak stimulus");
        end
    end

endmodule

/* csr_unit.f */
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/trap_if.sv
hdl/csr_access.sv
hdl/priv_state.sv
hdl/csr_regs.sv
hdl/trap_ctrl.sv
hdl/csr_unit.sv
dv/csr_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the csr_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module csr_unit_tb \
    -f csr_unit.f \
    -o csr_unit_sim

./obj_dir/csr_unit_sim
